// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_sd_card_spi
FILELIST  := sd_card_spi.f
LOG       := sim.log

SRCS := $(wildcard src/*.sv bench/*.sv)
BIN  := obj_dir/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

check:
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model
  import sd_pkg::*;
(
  input  logic sclk,
  input  logic mosi,
  input  logic cs,
  output logic miso
);

  byte_t       rx_sh;
  byte_t       tx_sh;
  byte_t       tx_next = IDLE_BYTE;
  int          bits = 0;
  byte_t       frame [6];
  int          frame_len = 0;
  byte_t       resp_q [$];
  logic        app_cmd = 1'b0;
  logic        streaming = 1'b0;
  logic [31:0] stream_addr;
  int          stream_pos;
  logic        frame_err = 1'b0;
  int          cmd0_cnt = 0;
  int          cmd8_cnt = 0;
  int          cmd55_cnt = 0;
  int          acmd41_cnt = 0;
  int          cmd59_cnt = 0;
  int          cmd18_cnt = 0;
  int          cmd12_cnt = 0;

  initial miso = 1'b1;

  // data pattern of block a, byte i
  function automatic byte_t block_byte(logic [31:0] a, int i);
    logic [31:0] s;
    s = a * 3 + i + (i >> 8);
    return s[7:0];
  endfunction

  task automatic decode_frame();
    logic [5:0]  cmd;
    logic [31:0] arg;
    cmd = frame[0][5:0];
    arg = {frame[1], frame[2], frame[3], frame[4]};
    resp_q.delete();
    resp_q.push_back(IDLE_BYTE);
    case (cmd)
      CMD0: begin
        cmd0_cnt++;
        if (frame[5] != 8'h95) frame_err = 1'b1;
        resp_q.push_back(R1_IDLE);
      end
      CMD8: begin
        cmd8_cnt++;
        if (frame[5] != 8'h87 || arg != CMD8_ECHO) frame_err = 1'b1;
        resp_q.push_back(R1_IDLE);
        for (int k = 3; k >= 0; k--) resp_q.push_back(arg[8*k +: 8]);
      end
      CMD55: begin
        cmd55_cnt++;
        resp_q.push_back(acmd41_cnt > 3 ? R1_READY : R1_IDLE);
      end
      ACMD41: begin
        if (!app_cmd) frame_err = 1'b1;
        acmd41_cnt++;
        // idle for the first three rounds
        resp_q.push_back(acmd41_cnt > 3 ? R1_READY : R1_IDLE);
      end
      CMD59: begin
        cmd59_cnt++;
        resp_q.push_back(R1_READY);
      end
      CMD18: begin
        cmd18_cnt++;
        if (arg < 32'h0010_0000) begin
          resp_q.push_back(R1_READY);
          streaming   = 1'b1;
          stream_addr = arg;
          stream_pos  = 0;
        end else begin
          resp_q.push_back(8'h20);
        end
      end
      CMD12: begin
        cmd12_cnt++;
        streaming = 1'b0;
        resp_q.push_back(R1_READY);
      end
      default: frame_err = 1'b1;
    endcase
    app_cmd = (cmd == CMD55);
  endtask

  // next byte on miso, responses first, then the block stream
  task automatic pick_next();
    if (resp_q.size() != 0) begin
      tx_next = resp_q.pop_front();
    end else if (streaming) begin
      if (stream_pos < 2) tx_next = IDLE_BYTE;
      else if (stream_pos == 2) tx_next = DATA_TOKEN;
      else if (stream_pos < BLOCK_BYTES + 3) tx_next = block_byte(stream_addr, stream_pos - 3);
      else tx_next = 8'h5A;
      stream_pos++;
      if (stream_pos == BLOCK_BYTES + 5) begin
        stream_pos  = 0;
        stream_addr = stream_addr + 1;
      end
    end else begin
      tx_next = IDLE_BYTE;
    end
  endtask

  always @(posedge sclk) begin
    rx_sh = {rx_sh[6:0], mosi};
    bits++;
    if (bits == 8) begin
      bits = 0;
      if (cs) begin
        frame_len = 0;
        streaming = 1'b0;
        resp_q.delete();
        tx_next = IDLE_BYTE;
      end else begin
        if (frame_len > 0 || rx_sh[7:6] == 2'b01) begin
          frame[frame_len] = rx_sh;
          frame_len++;
          if (frame_len == 6) begin
            frame_len = 0;
            decode_frame();
          end
        end
        pick_next();
      end
    end
  end

  always @(negedge sclk) begin
    if (bits == 0) tx_sh = tx_next;
    miso  = tx_sh[7];
    tx_sh = {tx_sh[6:0], 1'b1};
  end

endmodule

// File: bench/tb_sd_card_spi.sv
`timescale 1ns/1ps

module tb_sd_card_spi
  import sd_pkg::*;
();

  localparam int START_DIV  = 5;
  localparam int FAST_DIV   = 1;
  // four blocks at most plus command traffic
  localparam int TEST_BYTES = 4 * (BLOCK_BYTES + 20) + 200;
  localparam int LIMIT      = 60 * TEST_BYTES * 16 * FAST_DIV + 200000;

  logic       CLK;
  logic       RST;
  logic       rd_stb;
  blk_addr_t  rd_addr;
  blk_count_t rd_blocks;
  logic       rd_ack;
  logic       rd_err;
  logic       ready;
  logic       data_stb;
  byte_t      data;
  logic       sclk;
  logic       mosi;
  logic       miso;
  logic       cs;

  int        byte_count = 0;
  int        ack_count = 0;
  logic      last_err = 1'b0;
  int        data_errs = 0;
  int        seq_errs = 0;
  int        cycles = 0;
  blk_addr_t exp_base = '0;
  int        exp_start = 0;

  sd_card_spi #(
    .START_DIVIDER(START_DIV),
    .FAST_DIVIDER (FAST_DIV)
  ) sd_card_spi_i (
    .CLK(CLK), .RST(RST), .rd_stb(rd_stb), .rd_addr(rd_addr), .rd_blocks(rd_blocks),
    .rd_ack(rd_ack), .rd_err(rd_err), .ready(ready), .data_stb(data_stb), .data(data),
    .sclk(sclk), .mosi(mosi), .miso(miso), .cs(cs)
  );

  sd_card_model card_i (.sclk(sclk), .mosi(mosi), .cs(cs), .miso(miso));

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // expected byte i of block a
  function automatic byte_t expected_byte(blk_addr_t a, int i);
    logic [31:0] s;
    s = a * 3 + i + (i >> 8);
    return s[7:0];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
                       output bit bad);
    bad = (got !== exp);
    if (bad) $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  // ------------------------------------------------------------
  // compare process and host-side monitors
  // ------------------------------------------------------------
  always @(posedge CLK) begin
    int k;
    bit bad;
    if (data_stb) begin
      k = byte_count - exp_start;
      check("data", 32'(data),
            32'(expected_byte(exp_base + 32'(k / BLOCK_BYTES), k % BLOCK_BYTES)), bad);
      if (bad) data_errs <= data_errs + 1;
      byte_count <= byte_count + 1;
    end
    if (rd_ack) begin
      ack_count <= ack_count + 1;
      last_err  <= rd_err;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("errors: data %0d, sequence %0d", data_errs, seq_errs);
      $display("sim failed");
      $finish;
    end
  end

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    bit bad;
    check(name, got, exp, bad);
    if (bad) seq_errs++;
  endtask

  // one read with an optional second request while it runs
  task automatic run_read(input blk_addr_t addr, input blk_count_t blocks, input bit poke,
                          input bit want_err);
    int acks0;
    int start;
    int reqs0;
    acks0     = ack_count;
    start     = byte_count;
    reqs0     = card_i.cmd18_cnt;
    exp_base  = addr;
    exp_start = byte_count;
    @(posedge CLK);
    rd_addr   <= addr;
    rd_blocks <= blocks;
    rd_stb    <= 1'b1;
    @(posedge CLK);
    rd_stb <= 1'b0;
    if (poke) begin
      while (byte_count - start < 100) @(posedge CLK);
      rd_addr <= addr + 32'd7;
      rd_stb  <= 1'b1;
      @(posedge CLK);
      rd_stb <= 1'b0;
    end
    while (ack_count == acks0) @(posedge CLK);
    repeat (2000) @(posedge CLK);
    expect_eq("byte count", byte_count - start, want_err ? 0 : BLOCK_BYTES * int'(blocks));
    expect_eq("rd_ack count", ack_count - acks0, 1);
    expect_eq("rd_err", 32'(last_err), 32'(want_err));
    expect_eq("cmd18 count", card_i.cmd18_cnt - reqs0, 1);
  endtask

  initial begin
    blk_addr_t a;
    blk_count_t n;
    int stops;
    void'($urandom(32'h5eb8_456c));
    RST       = 1'b1;
    rd_stb    = 1'b0;
    rd_addr   = '0;
    rd_blocks = '0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    expect_eq("cs", 32'(cs), 1);
    expect_eq("sclk", 32'(sclk), 0);
    expect_eq("mosi", 32'(mosi), 1);
    expect_eq("ready", 32'(ready), 0);
    expect_eq("data_stb", 32'(data_stb), 0);
    expect_eq("rd_ack", 32'(rd_ack), 0);
    expect_eq("rd_err", 32'(rd_err), 0);

    // start-up sequence seen by the card
    while (!ready) @(posedge CLK);
    expect_eq("cmd0 seen", 32'(card_i.cmd0_cnt > 0), 1);
    expect_eq("cmd8 seen", 32'(card_i.cmd8_cnt > 0), 1);
    expect_eq("cmd55 rounds", 32'(card_i.cmd55_cnt >= 4), 1);
    expect_eq("acmd41 rounds", 32'(card_i.acmd41_cnt >= 4), 1);
    expect_eq("cmd59 seen", 32'(card_i.cmd59_cnt > 0), 1);

    a = $urandom % 32'h000F_FF00;
    run_read(a, 16'd1, 1'b0, 1'b0);

    a     = $urandom % 32'h000F_FF00;
    n     = blk_count_t'(2 + $urandom % 2);
    stops = card_i.cmd12_cnt;
    run_read(a, n, 1'b1, 1'b0);
    expect_eq("cmd12 after read", card_i.cmd12_cnt - stops, 1);

    a = 32'h0010_0000 + $urandom % 32'd1000;
    run_read(a, 16'd1, 1'b0, 1'b1);

    if (card_i.frame_err) begin
      $display("the card model received a malformed or unexpected command frame");
      seq_errs++;
    end
    $display("errors: data %0d, sequence %0d", data_errs, seq_errs);
    if (data_errs == 0 && seq_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: sd_card_spi.f
src/sd_pkg.sv
src/sd_clk_div.sv
src/spi_byte_shift.sv
src/sd_cmd_engine.sv
src/sd_block_reader.sv
src/sd_controller.sv
src/sd_card_spi.sv
bench/sd_card_model.sv
bench/tb_sd_card_spi.sv

// File: src/sd_block_reader.sv
`timescale 1ns/1ps

module sd_block_reader
  import sd_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  output logic  req,
  output byte_t req_data,
  input  logic  r_stb,
  input  byte_t r_data,
  output logic  data_stb,
  output byte_t data,
  output logic  done,
  output logic  timeout
);

  localparam int CNT_W  = $clog2(BLOCK_BYTES + 2);
  localparam int POLL_W = $clog2(TOKEN_POLL_LIMIT);

  typedef enum logic [1:0] {
    B_IDLE,
    B_TOKEN,
    B_STREAM
  } blk_state_t;

  blk_state_t        state;
  logic [CNT_W-1:0]  byte_cnt;
  logic [POLL_W-1:0] poll_cnt;

  assign req      = (state != B_IDLE);
  assign req_data = IDLE_BYTE;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= B_IDLE;
      byte_cnt <= '0;
      poll_cnt <= '0;
      data_stb <= 1'b0;
      done     <= 1'b0;
      timeout  <= 1'b0;
    end else begin
      data_stb <= 1'b0;
      done     <= 1'b0;
      if (start) begin
        state    <= B_TOKEN;
        poll_cnt <= '0;
        timeout  <= 1'b0;
      end else if (r_stb && state == B_TOKEN) begin
        byte_cnt <= '0;
        if (r_data == DATA_TOKEN) begin
          state <= B_STREAM;
        end else if (poll_cnt == POLL_W'(TOKEN_POLL_LIMIT - 1)) begin
          timeout <= 1'b1;
          done    <= 1'b1;
          state   <= B_IDLE;
        end else begin
          poll_cnt <= poll_cnt + 1'b1;
        end
      end else if (r_stb && state == B_STREAM) begin
        // the two trailing crc bytes are read but not passed on
        data_stb <= (byte_cnt < CNT_W'(BLOCK_BYTES));
        byte_cnt <= byte_cnt + 1'b1;
        if (byte_cnt == CNT_W'(BLOCK_BYTES + 1)) begin
          done  <= 1'b1;
          state <= B_IDLE;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (r_stb) data <= r_data;
  end

endmodule

// File: src/sd_card_spi.sv
`timescale 1ns/1ps

module sd_card_spi
  import sd_pkg::*;
#(
  parameter int START_DIVIDER = 5,
  parameter int FAST_DIVIDER  = 1
) (
  input  logic       CLK,
  input  logic       RST,
  input  logic       rd_stb,
  input  blk_addr_t  rd_addr,
  input  blk_count_t rd_blocks,
  output logic       rd_ack,
  output logic       rd_err,
  output logic       ready,
  output logic       data_stb,
  output byte_t      data,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso,
  output logic       cs
);

  logic  tick;
  logic  fast;
  logic  w_stb;
  byte_t w_data;
  logic  w_ready;
  logic  r_stb;
  byte_t r_data;

  // spi half-period tick, slow until start-up completes
  sd_clk_div #(
    .START_DIVIDER(START_DIVIDER),
    .FAST_DIVIDER (FAST_DIVIDER)
  ) clk_div_i (
    .CLK(CLK), .RST(RST), .fast(fast), .tick(tick)
  );

  spi_byte_shift shift_i (
    .CLK(CLK), .RST(RST), .tick(tick), .w_stb(w_stb), .w_data(w_data),
    .w_ready(w_ready), .r_stb(r_stb), .r_data(r_data),
    .sclk(sclk), .mosi(mosi), .miso(miso)
  );

  sd_controller ctrl_i (
    .CLK(CLK), .RST(RST), .rd_stb(rd_stb), .rd_addr(rd_addr), .rd_blocks(rd_blocks),
    .rd_ack(rd_ack), .rd_err(rd_err), .ready(ready), .fast(fast), .cs(cs),
    .w_stb(w_stb), .w_data(w_data), .w_ready(w_ready), .r_stb(r_stb), .r_data(r_data),
    .data_stb(data_stb), .data(data)
  );

endmodule

// File: src/sd_clk_div.sv
`timescale 1ns/1ps

module sd_clk_div #(
  parameter int START_DIVIDER = 5,
  parameter int FAST_DIVIDER  = 1
) (
  input  logic CLK,
  input  logic RST,
  input  logic fast,
  output logic tick
);

  logic [15:0] cnt;
  logic [15:0] reload;

  // new divider takes effect at the next reload
  assign reload = fast ? 16'(FAST_DIVIDER - 1) : 16'(START_DIVIDER - 1);
  assign tick   = (cnt == '0);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cnt <= 16'(START_DIVIDER - 1);
    end else if (tick) begin
      cnt <= reload;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // the card must not drop back to the start-up clock after init
  assert property (@(posedge CLK) disable iff (RST) !$fell(fast));

endmodule

// File: src/sd_cmd_engine.sv
`timescale 1ns/1ps

module sd_cmd_engine
  import sd_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        start,
  input  sd_cmd_t     op,
  input  blk_addr_t   arg,
  output logic        req,
  output byte_t       req_data,
  input  logic        r_stb,
  input  byte_t       r_data,
  output logic        done,
  output byte_t       r1,
  output logic [31:0] r7,
  output logic        timeout
);

  localparam int POLL_W = $clog2(R1_POLL_LIMIT);

  typedef enum logic [2:0] {
    E_IDLE,
    E_FRAME,
    E_POLL,
    E_TRAIL,
    E_TAIL
  } eng_state_t;

  eng_state_t        state;
  sd_cmd_t           op_q;
  blk_addr_t         arg_q;
  logic [2:0]        idx;
  logic [POLL_W-1:0] poll_cnt;
  byte_t             crc;

  // only CMD0 and CMD8 are checked by the card before CMD59
  always_comb begin
    case (op_q)
      CMD0:    crc = 8'h95;
      CMD8:    crc = 8'h87;
      default: crc = IDLE_BYTE;
    endcase
  end

  assign req = (state != E_IDLE);

  always_comb begin
    req_data = IDLE_BYTE;
    if (state == E_FRAME) begin
      case (idx)
        3'd0:    req_data = {2'b01, op_q};
        3'd5:    req_data = crc;
        default: req_data = arg_q[31:24];
      endcase
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= E_IDLE;
      op_q     <= CMD0;
      idx      <= '0;
      poll_cnt <= '0;
      done     <= 1'b0;
      timeout  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        state   <= E_FRAME;
        op_q    <= op;
        idx     <= '0;
        timeout <= 1'b0;
      end else if (r_stb) begin
        case (state)
          E_FRAME: begin
            idx      <= idx + 1'b1;
            poll_cnt <= '0;
            if (idx == 3'd5) state <= E_POLL;
          end
          E_POLL: begin
            if (!r_data[7]) begin
              idx   <= '0;
              state <= (op_q == CMD8) ? E_TRAIL : E_TAIL;
            end else if (poll_cnt == POLL_W'(R1_POLL_LIMIT - 1)) begin
              timeout <= 1'b1;
              state   <= E_TAIL;
            end else begin
              poll_cnt <= poll_cnt + 1'b1;
            end
          end
          E_TRAIL: begin
            idx <= idx + 1'b1;
            if (idx == 3'd3) state <= E_TAIL;
          end
          E_TAIL: begin
            done  <= 1'b1;
            state <= E_IDLE;
          end
          default: state <= E_IDLE;
        endcase
      end
    end
  end

  // argument shifter and response capture
  always_ff @(posedge CLK) begin
    if (start) begin
      arg_q <= arg;
      r1    <= IDLE_BYTE;
      r7    <= '0;
    end else if (r_stb) begin
      if (state == E_FRAME && idx != 3'd0) arg_q <= {arg_q[23:0], 8'h00};
      if (state == E_POLL && !r_data[7]) r1 <= r_data;
      if (state == E_TRAIL) r7 <= {r7[23:0], r_data};
    end
  end

endmodule

// File: src/sd_controller.sv
`timescale 1ns/1ps

module sd_controller
  import sd_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       rd_stb,
  input  blk_addr_t  rd_addr,
  input  blk_count_t rd_blocks,
  output logic       rd_ack,
  output logic       rd_err,
  output logic       ready,
  output logic       fast,
  output logic       cs,
  output logic       w_stb,
  output byte_t      w_data,
  input  logic       w_ready,
  input  logic       r_stb,
  input  byte_t      r_data,
  output logic       data_stb,
  output byte_t      data
);

  localparam int DUMMY_W = $clog2(DUMMY_BYTES);
  localparam int ATT_W   = $clog2(INIT_ATTEMPTS);
  // high capacity support bit in the ACMD41 argument
  localparam blk_addr_t ACMD41_HCS = 32'h4000_0000;

  typedef enum logic [2:0] {
    ST_DUMMY,
    ST_GAP,
    ST_CMD,
    ST_BLOCK,
    ST_IDLE
  } ctl_state_t;

  ctl_state_t         state;
  sd_cmd_t            cmd_op;
  blk_addr_t          cmd_arg;
  blk_addr_t          addr_q;
  blk_count_t         blocks_left;
  logic [DUMMY_W-1:0] dummy_cnt;
  logic [ATT_W-1:0]   attempts;
  logic               gap_to_cmd;
  logic               busy_rd;
  logic               rd_fail;
  logic               in_flight;
  logic               cmd_start;
  logic               cmd_req;
  byte_t              cmd_data;
  logic               cmd_done;
  byte_t              cmd_r1;
  logic [31:0]        cmd_r7;
  logic               cmd_timeout;
  logic               blk_start;
  logic               blk_req;
  byte_t              blk_data;
  logic               blk_done;
  logic               blk_timeout;
  logic               mux_req;
  byte_t              mux_data;

  function automatic blk_addr_t arg_for(sd_cmd_t op, blk_addr_t addr);
    case (op)
      CMD8:    return CMD8_ECHO;
      ACMD41:  return ACMD41_HCS;
      CMD18:   return addr;
      default: return '0;
    endcase
  endfunction

  assign cmd_arg = arg_for(cmd_op, addr_q);
  // card is selected from the command frame to the end of its response
  assign cs      = !(state inside {ST_CMD, ST_BLOCK});

  sd_cmd_engine cmd_i (
    .CLK(CLK), .RST(RST), .start(cmd_start), .op(cmd_op), .arg(cmd_arg),
    .req(cmd_req), .req_data(cmd_data), .r_stb(r_stb), .r_data(r_data),
    .done(cmd_done), .r1(cmd_r1), .r7(cmd_r7), .timeout(cmd_timeout)
  );

  sd_block_reader blk_i (
    .CLK(CLK), .RST(RST), .start(blk_start), .req(blk_req), .req_data(blk_data),
    .r_stb(r_stb), .r_data(r_data), .data_stb(data_stb), .data(data),
    .done(blk_done), .timeout(blk_timeout)
  );

  // ------------------------------------------------------------
  // byte request multiplexer
  // ------------------------------------------------------------
  always_comb begin
    mux_req  = 1'b0;
    mux_data = IDLE_BYTE;
    case (state)
      ST_CMD: begin
        mux_req  = cmd_req;
        mux_data = cmd_data;
      end
      ST_BLOCK: begin
        mux_req  = blk_req;
        mux_data = blk_data;
      end
      ST_DUMMY, ST_GAP: mux_req = 1'b1;
      default: mux_req = 1'b0;
    endcase
  end

  // one byte in flight, next request is looked at after r_stb
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_stb     <= 1'b0;
      w_data    <= IDLE_BYTE;
      in_flight <= 1'b0;
    end else begin
      w_stb <= 1'b0;
      if (r_stb) begin
        in_flight <= 1'b0;
      end else if (!in_flight && mux_req && w_ready) begin
        w_stb     <= 1'b1;
        w_data    <= mux_data;
        in_flight <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // start-up and read sequencing
  // ------------------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= ST_DUMMY;
      cmd_op      <= CMD0;
      addr_q      <= '0;
      blocks_left <= '0;
      dummy_cnt   <= '0;
      attempts    <= '0;
      gap_to_cmd  <= 1'b0;
      busy_rd     <= 1'b0;
      rd_fail     <= 1'b0;
      cmd_start   <= 1'b0;
      blk_start   <= 1'b0;
      rd_ack      <= 1'b0;
      rd_err      <= 1'b0;
      ready       <= 1'b0;
      fast        <= 1'b0;
    end else begin
      cmd_start <= 1'b0;
      blk_start <= 1'b0;
      rd_ack    <= 1'b0;
      rd_err    <= 1'b0;
      case (state)
        ST_DUMMY: if (r_stb) begin
          dummy_cnt <= dummy_cnt + 1'b1;
          if (dummy_cnt == DUMMY_W'(DUMMY_BYTES - 1)) begin
            cmd_op     <= CMD0;
            gap_to_cmd <= 1'b1;
            state      <= ST_GAP;
          end
        end
        ST_GAP: if (r_stb) begin
          if (gap_to_cmd) begin
            cmd_start <= 1'b1;
            state     <= ST_CMD;
          end else begin
            ready   <= 1'b1;
            rd_ack  <= busy_rd;
            rd_err  <= busy_rd && rd_fail;
            busy_rd <= 1'b0;
            state   <= ST_IDLE;
          end
        end
        ST_CMD: if (cmd_done) begin
          // a failed start-up step falls back to CMD0
          state      <= ST_GAP;
          gap_to_cmd <= 1'b1;
          cmd_op     <= CMD0;
          case (cmd_op)
            CMD0:  if (cmd_r1 == R1_IDLE) cmd_op <= CMD8;
            CMD8: if (cmd_r1 == R1_IDLE && cmd_r7 == CMD8_ECHO) begin
              attempts <= '0;
              cmd_op   <= CMD55;
            end
            CMD55: if (cmd_r1 == R1_IDLE || cmd_r1 == R1_READY) cmd_op <= ACMD41;
            ACMD41: begin
              if (cmd_r1 == R1_READY) begin
                cmd_op <= CMD59;
              end else if (cmd_r1 == R1_IDLE && attempts != ATT_W'(INIT_ATTEMPTS - 1)) begin
                attempts <= attempts + 1'b1;
                cmd_op   <= CMD55;
              end
            end
            CMD59: if (cmd_r1 == R1_READY) begin
              fast       <= 1'b1;
              gap_to_cmd <= 1'b0;
            end
            CMD18: begin
              if (cmd_r1 == R1_READY && !cmd_timeout) begin
                blk_start <= 1'b1;
                state     <= ST_BLOCK;
              end else begin
                rd_fail    <= 1'b1;
                gap_to_cmd <= 1'b0;
              end
            end
            default: gap_to_cmd <= 1'b0;
          endcase
        end
        ST_BLOCK: if (blk_done) begin
          blocks_left <= blocks_left - 1'b1;
          if (blk_timeout || blocks_left == blk_count_t'(1)) begin
            rd_fail   <= rd_fail || blk_timeout;
            cmd_op    <= CMD12;
            cmd_start <= 1'b1;
            state     <= ST_CMD;
          end else begin
            blk_start <= 1'b1;
          end
        end
        ST_IDLE: if (rd_stb) begin
          addr_q      <= rd_addr;
          blocks_left <= rd_blocks;
          busy_rd     <= 1'b1;
          rd_fail     <= 1'b0;
          cmd_op      <= CMD18;
          gap_to_cmd  <= 1'b1;
          state       <= ST_GAP;
        end
        default: state <= ST_DUMMY;
      endcase
    end
  end

  assert property (@(posedge CLK) disable iff (RST) !(cmd_req && blk_req));

endmodule

// File: src/sd_pkg.sv
package sd_pkg;

  // ------------------------------------------------------------
  // command indices, SPI mode
  // ------------------------------------------------------------
  typedef enum logic [5:0] {
    CMD0   = 6'd0,
    CMD8   = 6'd8,
    CMD12  = 6'd12,
    CMD18  = 6'd18,
    ACMD41 = 6'd41,
    CMD55  = 6'd55,
    CMD59  = 6'd59
  } sd_cmd_t;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] blk_addr_t;
  typedef logic [15:0] blk_count_t;

  // ------------------------------------------------------------
  // protocol constants
  // ------------------------------------------------------------
  localparam int BLOCK_BYTES = 512;

  localparam byte_t DATA_TOKEN = 8'hFE;
  localparam byte_t IDLE_BYTE  = 8'hFF;

  // r1 values seen during start-up and reads
  localparam byte_t R1_IDLE  = 8'h01;
  localparam byte_t R1_READY = 8'h00;

  // voltage range and check pattern echoed in the r7 trailer
  localparam logic [31:0] CMD8_ECHO = 32'h0000_01AA;

  localparam int R1_POLL_LIMIT    = 16;
  localparam int TOKEN_POLL_LIMIT = 1024;
  localparam int INIT_ATTEMPTS    = 64;
  localparam int DUMMY_BYTES      = 10;

endpackage

// File: src/spi_byte_shift.sv
`timescale 1ns/1ps

module spi_byte_shift
  import sd_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  tick,
  input  logic  w_stb,
  input  byte_t w_data,
  output logic  w_ready,
  output logic  r_stb,
  output byte_t r_data,
  output logic  sclk,
  output logic  mosi,
  input  logic  miso
);

  logic       busy;
  logic [2:0] bit_cnt;
  byte_t      tx_sh;
  byte_t      rx_sh;

  // mode 0: sample on the rising tick, shift on the falling tick
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      w_ready <= 1'b1;
      r_stb   <= 1'b0;
      sclk    <= 1'b0;
      mosi    <= 1'b1;
      bit_cnt <= '0;
    end else begin
      r_stb <= 1'b0;
      if (w_stb) begin
        busy    <= 1'b1;
        w_ready <= 1'b0;
        mosi    <= w_data[7];
        bit_cnt <= '0;
      end else if (busy && tick) begin
        if (!sclk) begin
          sclk <= 1'b1;
        end else begin
          sclk <= 1'b0;
          if (bit_cnt == 3'd7) begin
            // eighth bit already sampled, byte complete
            busy    <= 1'b0;
            w_ready <= 1'b1;
            r_stb   <= 1'b1;
            mosi    <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= tx_sh[7];
          end
        end
      end
    end
  end

  // shift registers
  always_ff @(posedge CLK) begin
    if (w_stb) begin
      tx_sh <= {w_data[6:0], 1'b1};
    end else if (busy && tick) begin
      if (!sclk) begin
        rx_sh <= {rx_sh[6:0], miso};
      end else begin
        tx_sh <= {tx_sh[6:0], 1'b1};
        if (bit_cnt == 3'd7) r_data <= rx_sh;
      end
    end
  end

  assert property (@(posedge CLK) disable iff (RST) w_stb |-> w_ready);

endmodule
